//--- src/compPkg.sv
package compPkg;

   localparam int wordWidth = 32;
   localparam int addrWidth = 8;
   localparam int regCount = 16;
   localparam int regIdxWidth = $clog2(regCount);
   localparam int immWidth = 16;
   localparam int shiftWidth = $clog2(wordWidth);

   // Instruction field positions
   localparam int opcodeMsb = 31;
   localparam int opcodeLsb = 28;
   localparam int rdMsb = 27;
   localparam int rdLsb = 24;
   localparam int raMsb = 23;
   localparam int raLsb = 20;
   localparam int rbMsb = 19;
   localparam int rbLsb = 16;
   localparam int immMsb = 15;
   localparam int immLsb = 0;

   typedef logic [wordWidth-1:0] word_t;
   typedef logic [addrWidth-1:0] addr_t;
   typedef logic [regIdxWidth-1:0] regIdx_t;

   typedef enum logic [opcodeMsb-opcodeLsb:0] {
      opNop = 4'h0,
      opLdi = 4'h1,  // Sign-extended immediate
      opLui = 4'h2,  // Immediate into upper half
      opOri = 4'h3,
      opAdd = 4'h4,
      opSub = 4'h5,
      opAnd = 4'h6,
      opOr  = 4'h7,
      opXor = 4'h8,
      opShl = 4'h9,
      opShr = 4'ha,
      opIn  = 4'hb,  // imm[0] picks portI or portJ
      opOut = 4'hc,  // imm[1:0] picks portA..portD
      opJmp = 4'hd,
      opJz  = 4'he   // Codes above this decode as opNop
   } opcode_t;

   typedef enum logic [1:0] {
      stFetch,
      stExec,
      stResult
   } state_t;

endpackage

//--- src/instrDecode.sv
module instrDecode
(
   input  logic                           selected_clk,
   input  logic                           res,
   input  compPkg::word_t                 instr,
   input  logic                           branchTaken,
   input  compPkg::addr_t                 target,
   output compPkg::addr_t                 addr,
   output compPkg::state_t                state,
   output compPkg::opcode_t               opcode,
   output compPkg::regIdx_t               rd,
   output compPkg::regIdx_t               ra,
   output compPkg::regIdx_t               rb,
   output logic [compPkg::immWidth-1:0]   imm,
   output logic                           retire
);

   import compPkg::*;

   addr_t pc;
   logic [opcodeMsb-opcodeLsb:0] rawOp;
   opcode_t decodedOp;

   assign addr = pc;
   assign retire = (state == stResult);
   assign rawOp = instr[opcodeMsb:opcodeLsb];

   always_comb
   begin
      if (rawOp > opJz)
      begin
         decodedOp = opNop;  // Unused codes
      end
      else
      begin
         decodedOp = opcode_t'(rawOp);
      end
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         state <= stFetch;
         pc <= '0;
         opcode <= opNop;
      end
      else
      begin
         case (state)
            stFetch:
            begin
               state <= stExec;
               opcode <= decodedOp;
            end
            stExec:
            begin
               state <= stResult;
            end
            default:
            begin
               state <= stFetch;
               pc <= branchTaken ? target : pc + 1'b1;  // Wraps at 256
            end
         endcase
      end
   end

   // Operand fields follow the opcode latch
   always_ff @(posedge selected_clk)
   begin
      if (state == stFetch)
      begin
         rd <= instr[rdMsb:rdLsb];
         ra <= instr[raMsb:raLsb];
         rb <= instr[rbMsb:rbLsb];
         imm <= instr[immMsb:immLsb];
      end
   end

endmodule

//--- src/aluExecute.sv
module aluExecute
(
   input  logic                           selected_clk,
   input  logic                           res,
   input  compPkg::state_t                state,
   input  compPkg::opcode_t               opcode,
   input  compPkg::regIdx_t               rd,
   input  compPkg::regIdx_t               ra,
   input  compPkg::regIdx_t               rb,
   input  logic [compPkg::immWidth-1:0]   imm,
   input  compPkg::word_t                 raData,
   input  compPkg::word_t                 rbData,
   input  compPkg::word_t                 portI,
   input  compPkg::word_t                 portJ,
   output compPkg::regIdx_t               raIdx,
   output compPkg::regIdx_t               rbIdx,
   output compPkg::regIdx_t               rdOut,
   output compPkg::word_t                 result,
   output logic                           writeReg,
   output logic                           writePort,
   output logic                           branchTaken,
   output logic [1:0]                     portSel,
   output compPkg::addr_t                 target
);

   import compPkg::*;

   word_t nextResult;
   logic nextWriteReg;
   logic nextBranch;
   logic [shiftWidth-1:0] shiftAmt;

   assign raIdx = ra;
   assign rbIdx = rb;
   assign shiftAmt = rbData[shiftWidth-1:0];

   always_comb
   begin
      nextWriteReg = opcode inside {opLdi, opLui, opOri, opAdd, opSub, opAnd,
                                    opOr, opXor, opShl, opShr, opIn};
      nextBranch = (opcode == opJmp) || (opcode == opJz && raData == '0);
      case (opcode)
         opLdi: nextResult = {{(wordWidth-immWidth){imm[immWidth-1]}}, imm};
         opLui: nextResult = {imm, {(wordWidth-immWidth){1'b0}}};
         opOri: nextResult = raData | {{(wordWidth-immWidth){1'b0}}, imm};
         opAdd: nextResult = raData + rbData;
         opSub: nextResult = raData - rbData;
         opAnd: nextResult = raData & rbData;
         opOr:  nextResult = raData | rbData;
         opXor: nextResult = raData ^ rbData;
         opShl: nextResult = raData << shiftAmt;
         opShr: nextResult = raData >> shiftAmt;
         opIn:  nextResult = imm[0] ? portJ : portI;
         default: nextResult = raData;  // opOut value
      endcase
   end

   // Strobes live only for the stResult cycle
   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         writeReg <= 1'b0;
         writePort <= 1'b0;
         branchTaken <= 1'b0;
      end
      else if (state == stExec)
      begin
         writeReg <= nextWriteReg;
         writePort <= (opcode == opOut);
         branchTaken <= nextBranch;
      end
      else
      begin
         writeReg <= 1'b0;
         writePort <= 1'b0;
         branchTaken <= 1'b0;
      end
   end

   always_ff @(posedge selected_clk)
   begin
      if (state == stExec)
      begin
         result <= nextResult;
         rdOut <= rd;
         portSel <= imm[1:0];
         target <= imm[addrWidth-1:0];
      end
   end

endmodule

//--- src/resultWrite.sv
module resultWrite
(
   input  logic               selected_clk,
   input  logic               res,
   input  compPkg::state_t    state,
   input  logic               writeReg,
   input  logic               writePort,
   input  compPkg::regIdx_t   rdOut,
   input  compPkg::regIdx_t   raIdx,
   input  compPkg::regIdx_t   rbIdx,
   input  compPkg::regIdx_t   testRegSel,
   input  logic [1:0]         portSel,
   input  compPkg::word_t     result,
   output compPkg::word_t     raData,
   output compPkg::word_t     rbData,
   output compPkg::word_t     testReg,
   output compPkg::word_t     portA,
   output compPkg::word_t     portB,
   output compPkg::word_t     portC,
   output compPkg::word_t     portD
);

   import compPkg::*;

   word_t regs [regCount];

   // r0 is hardwired to zero
   assign raData = (raIdx == '0) ? '0 : regs[raIdx];
   assign rbData = (rbIdx == '0) ? '0 : regs[rbIdx];
   assign testReg = (testRegSel == '0) ? '0 : regs[testRegSel];

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         for (int i = 0; i < regCount; i++)
         begin
            regs[i] <= '0;
         end
      end
      else if (state == stResult && writeReg && rdOut != '0)
      begin
         regs[rdOut] <= result;
      end
   end

   always_ff @(posedge selected_clk or posedge res)
   begin
      if (res)
      begin
         portA <= '0;
         portB <= '0;
         portC <= '0;
         portD <= '0;
      end
      else if (state == stResult && writePort)
      begin
         case (portSel)
            2'd0: portA <= result;
            2'd1: portB <= result;
            2'd2: portC <= result;
            default: portD <= result;
         endcase
      end
   end

endmodule

//--- src/comp.sv
module comp
(
   input  logic               selected_clk,
   input  logic               res,
   input  compPkg::word_t     instr,
   input  compPkg::word_t     portI,
   input  compPkg::word_t     portJ,
   input  compPkg::regIdx_t   testRegSel,
   output compPkg::addr_t     addr,
   output compPkg::word_t     portA,
   output compPkg::word_t     portB,
   output compPkg::word_t     portC,
   output compPkg::word_t     portD,
   output compPkg::word_t     testReg,
   output logic               retire
);

   import compPkg::*;

   state_t state;
   opcode_t opcode;
   regIdx_t rd;
   regIdx_t ra;
   regIdx_t rb;
   logic [immWidth-1:0] imm;
   regIdx_t raIdx;
   regIdx_t rbIdx;
   regIdx_t rdOut;
   word_t raData;
   word_t rbData;
   word_t result;
   logic writeReg;
   logic writePort;
   logic branchTaken;
   logic [1:0] portSel;
   addr_t target;

   instrDecode decode_i
   (
      .selected_clk  (selected_clk),
      .res           (res),
      .instr         (instr),
      .branchTaken   (branchTaken),
      .target        (target),
      .addr          (addr),
      .state         (state),
      .opcode        (opcode),
      .rd            (rd),
      .ra            (ra),
      .rb            (rb),
      .imm           (imm),
      .retire        (retire)
   );

   aluExecute execute_i
   (
      .selected_clk  (selected_clk),
      .res           (res),
      .state         (state),
      .opcode        (opcode),
      .rd            (rd),
      .ra            (ra),
      .rb            (rb),
      .imm           (imm),
      .raData        (raData),
      .rbData        (rbData),
      .portI         (portI),
      .portJ         (portJ),
      .raIdx         (raIdx),
      .rbIdx         (rbIdx),
      .rdOut         (rdOut),
      .result        (result),
      .writeReg      (writeReg),
      .writePort     (writePort),
      .branchTaken   (branchTaken),
      .portSel       (portSel),
      .target        (target)
   );

   resultWrite write_i
   (
      .selected_clk  (selected_clk),
      .res           (res),
      .state         (state),
      .writeReg      (writeReg),
      .writePort     (writePort),
      .rdOut         (rdOut),
      .raIdx         (raIdx),
      .rbIdx         (rbIdx),
      .testRegSel    (testRegSel),
      .portSel       (portSel),
      .result        (result),
      .raData        (raData),
      .rbData        (rbData),
      .testReg       (testReg),
      .portA         (portA),
      .portB         (portB),
      .portC         (portC),
      .portD         (portD)
   );

endmodule

//--- sim/tbClock.sv
module tbClock
(
   output logic selected_clk,
   output logic res
);

   initial
   begin
      selected_clk = 1'b0;
      res = 1'b1;
      repeat (5) @(posedge selected_clk);
      #1 res = 1'b0;  // Power-on reset for 5 cycles
   end

   always #5 selected_clk = ~selected_clk;

endmodule

//--- sim/compTb.sv
module compTb;

   import compPkg::*;

   logic selected_clk;
   logic powerRes;
   logic taskRes = 1'b0;
   logic res;
   word_t instr = '0;
   word_t portI = '0;
   word_t portJ = '0;
   regIdx_t testRegSel = '0;
   addr_t addr;
   word_t portA;
   word_t portB;
   word_t portC;
   word_t portD;
   word_t testReg;
   logic retire;

   word_t progMem [256];
   addr_t progPos = '0;
   word_t rngState = 32'h96ab;
   int cycleCount = 0;

   assign res = powerRes | taskRes;

   tbClock clock_i
   (
      .selected_clk  (selected_clk),
      .res           (powerRes)
   );

   comp comp_i
   (
      .selected_clk  (selected_clk),
      .res           (res),
      .instr         (instr),
      .portI         (portI),
      .portJ         (portJ),
      .testRegSel    (testRegSel),
      .addr          (addr),
      .portA         (portA),
      .portB         (portB),
      .portC         (portC),
      .portD         (portD),
      .testReg       (testReg),
      .retire        (retire)
   );

   always @(posedge selected_clk)
   begin
      #1 instr = progMem[addr];  // Memory answers within stFetch
   end

   always @(posedge selected_clk)
   begin
      cycleCount <= cycleCount + 1;
   end

   function automatic word_t nextRandom();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState;
   endfunction

   function automatic word_t encode(opcode_t op, regIdx_t rd, regIdx_t ra, regIdx_t rb,
                                    logic [15:0] imm);
      return {op, rd, ra, rb, imm};
   endfunction

   task automatic abortRun(string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic checkWord(word_t got, word_t exp, string name);
      if (got !== exp)
      begin
         abortRun($sformatf("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp));
      end
   endtask

   task automatic checkAddr(addr_t got, addr_t exp, string name);
      if (got !== exp)
      begin
         abortRun($sformatf("FAIL %s: got 0x%02h, expected 0x%02h", name, got, exp));
      end
   endtask

   task automatic checkBit(logic got, logic exp, string name);
      if (got !== exp)
      begin
         abortRun($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic emit(word_t w);
      progMem[progPos] = w;
      progPos = progPos + 8'd1;
   endtask

   task automatic emitHalt();
      emit(encode(opJmp, 4'd0, 4'd0, 4'd0, {8'h00, progPos}));  // Jump to itself
   endtask

   task automatic clearProgram();
      for (int i = 0; i < 256; i++)
      begin
         progMem[i] = encode(opJmp, 4'd0, 4'd0, 4'd0, {8'h00, 8'(i)});  // Stray fetches spin
      end
      progPos = '0;
   endtask

   task automatic setReset(logic level);
      @(posedge selected_clk);
      #1 taskRes = level;
   endtask

   task automatic resetCpu();
      setReset(1'b1);
      repeat (4) @(posedge selected_clk);
      setReset(1'b0);
   endtask

   task automatic waitPowerReset();
      int cycles;
      cycles = 0;
      while (powerRes && cycles < 200)
      begin
         @(negedge selected_clk);
         cycles++;
      end
      if (powerRes)
      begin
         abortRun("Timeout: power-on reset was never released");
      end
   endtask

   task automatic waitRetire(int count);
      int cycles;
      for (int n = 0; n < count; n++)
      begin
         cycles = 0;
         do
         begin
            @(negedge selected_clk);
            cycles++;
         end
         while (!retire && cycles < 200);
         if (!retire)
         begin
            abortRun("Timeout: the CPU never retired an instruction");
         end
      end
   endtask

   // Last retire seen at its stResult, so one more cycle lets the write land
   task automatic runProgram(int count);
      resetCpu();
      waitRetire(count);
      @(negedge selected_clk);
   endtask

   task automatic expectReg(regIdx_t idx, word_t exp, string name);
      @(posedge selected_clk);
      #1 testRegSel = idx;
      @(negedge selected_clk);
      checkWord(testReg, exp, name);
   endtask

   task automatic stepTo(addr_t exp, string name);
      waitRetire(1);
      @(negedge selected_clk);
      checkAddr(addr, exp, name);
   endtask

   task automatic resetBehavior();
      clearProgram();
      emit(encode(opLdi, 4'd5, 4'd0, 4'd0, 16'h1234));
      emit(encode(opOut, 4'd0, 4'd5, 4'd0, 16'd0));
      emitHalt();
      runProgram(2);
      checkWord(portA, 32'h0000_1234, "portA before reset");
      setReset(1'b1);
      @(negedge selected_clk);
      checkWord(portA, '0, "portA in reset");
      checkWord(portB, '0, "portB in reset");
      checkWord(portC, '0, "portC in reset");
      checkWord(portD, '0, "portD in reset");
      for (int i = 0; i < 16; i++)
      begin
         expectReg(regIdx_t'(i), '0, $sformatf("testReg r%0d in reset", i));
         checkAddr(addr, '0, "addr in reset");
         checkBit(retire, 1'b0, "retire in reset");
      end
      setReset(1'b0);
      @(negedge selected_clk);
      checkAddr(addr, '0, "addr after reset");
      checkBit(retire, 1'b0, "retire after reset");
   endtask

   task automatic arithLogic();
      word_t a;
      word_t b;
      a = nextRandom();
      b = nextRandom();
      clearProgram();
      emit(encode(opLui, 4'd1, 4'd0, 4'd0, a[31:16]));
      emit(encode(opOri, 4'd1, 4'd1, 4'd0, a[15:0]));
      emit(encode(opLui, 4'd2, 4'd0, 4'd0, b[31:16]));
      emit(encode(opOri, 4'd2, 4'd2, 4'd0, b[15:0]));
      emit(encode(opAdd, 4'd3, 4'd1, 4'd2, 16'd0));
      emit(encode(opSub, 4'd4, 4'd1, 4'd2, 16'd0));
      emit(encode(opAnd, 4'd5, 4'd1, 4'd2, 16'd0));
      emit(encode(opOr, 4'd6, 4'd1, 4'd2, 16'd0));
      emit(encode(opXor, 4'd7, 4'd1, 4'd2, 16'd0));
      emit(encode(opShl, 4'd8, 4'd1, 4'd2, 16'd0));
      emit(encode(opShr, 4'd9, 4'd1, 4'd2, 16'd0));
      emitHalt();
      runProgram(11);
      expectReg(4'd1, a, "testReg r1 lui/ori");
      expectReg(4'd2, b, "testReg r2 lui/ori");
      expectReg(4'd3, a + b, "testReg r3 add");
      expectReg(4'd4, a - b, "testReg r4 sub");
      expectReg(4'd5, a & b, "testReg r5 and");
      expectReg(4'd6, a | b, "testReg r6 or");
      expectReg(4'd7, a ^ b, "testReg r7 xor");
      expectReg(4'd8, a << b[4:0], "testReg r8 shl");
      expectReg(4'd9, a >> b[4:0], "testReg r9 shr");
   endtask

   task automatic portIo();
      word_t inI;
      word_t inJ;
      inI = nextRandom();
      inJ = nextRandom();
      @(posedge selected_clk);
      #1 portI = inI;
      portJ = inJ;
      clearProgram();
      emit(encode(opIn, 4'd1, 4'd0, 4'd0, 16'd0));
      emit(encode(opIn, 4'd2, 4'd0, 4'd0, 16'd1));
      emit(encode(opOut, 4'd0, 4'd1, 4'd0, 16'd0));
      emit(encode(opOut, 4'd0, 4'd2, 4'd0, 16'd1));
      emit(encode(opAdd, 4'd3, 4'd1, 4'd2, 16'd0));
      emit(encode(opOut, 4'd0, 4'd3, 4'd0, 16'd2));
      emit(encode(opLdi, 4'd4, 4'd0, 4'd0, 16'h8001));
      emit(encode(opOut, 4'd0, 4'd4, 4'd0, 16'd3));
      emitHalt();
      runProgram(8);
      expectReg(4'd1, inI, "testReg r1 in portI");
      expectReg(4'd2, inJ, "testReg r2 in portJ");
      checkWord(portA, inI, "portA");
      checkWord(portB, inJ, "portB");
      checkWord(portC, inI + inJ, "portC");
      checkWord(portD, 32'hffff_8001, "portD");
   endtask

   task automatic controlFlow();
      clearProgram();
      emit(encode(opLdi, 4'd1, 4'd0, 4'd0, 16'h0055));
      emit(encode(opJmp, 4'd0, 4'd0, 4'd0, 16'h3304));  // Only low 8 bits count
      emit(encode(opLdi, 4'd2, 4'd0, 4'd0, 16'h0077));
      emit(encode(opOut, 4'd0, 4'd2, 4'd0, 16'd0));
      emit(encode(opJz, 4'd0, 4'd0, 4'd0, 16'h0007));
      emit(encode(opLdi, 4'd3, 4'd0, 4'd0, 16'h0001));
      emit(encode(opOut, 4'd0, 4'd3, 4'd0, 16'd0));
      emit(encode(opJz, 4'd0, 4'd1, 4'd0, 16'h0020));
      emit(encode(opLdi, 4'd4, 4'd0, 4'd0, 16'h0099));
      emit(encode(opOut, 4'd0, 4'd4, 4'd0, 16'd1));
      emitHalt();
      resetCpu();
      @(negedge selected_clk);
      checkAddr(addr, 8'h00, "addr first fetch");
      stepTo(8'h01, "addr after ldi");
      stepTo(8'h04, "addr after jmp");
      stepTo(8'h07, "addr after taken jz");
      stepTo(8'h08, "addr after untaken jz");
      stepTo(8'h09, "addr after ldi r4");
      stepTo(8'h0a, "addr after out");
      checkWord(portA, '0, "portA skipped");
      checkWord(portB, 32'h0000_0099, "portB");
      expectReg(4'd2, '0, "testReg r2 skipped");
      expectReg(4'd3, '0, "testReg r3 skipped");
      expectReg(4'd4, 32'h0000_0099, "testReg r4");
   endtask

   task automatic retireTiming();
      int lastCycle;
      clearProgram();
      repeat (6) emit(encode(opNop, 4'd0, 4'd0, 4'd0, 16'd0));
      emitHalt();
      resetCpu();
      waitRetire(1);
      checkAddr(addr, 8'h00, "addr at retire");
      lastCycle = cycleCount;
      for (int i = 1; i < 6; i++)
      begin
         waitRetire(1);
         checkAddr(addr, 8'(i), "addr at retire");
         checkWord(word_t'(cycleCount - lastCycle), 32'd3, "retire spacing");
         lastCycle = cycleCount;
      end
   endtask

   task automatic regZeroAndSignExt();
      clearProgram();
      emit(encode(opLdi, 4'd0, 4'd0, 4'd0, 16'h1234));
      emit(encode(opLdi, 4'd5, 4'd0, 4'd0, 16'hff85));
      emit(encode(opLdi, 4'd6, 4'd0, 4'd0, 16'h7fff));
      emit(encode(opAdd, 4'd7, 4'd0, 4'd6, 16'd0));  // r0 as an operand
      emitHalt();
      runProgram(4);
      expectReg(4'd0, '0, "testReg r0");
      expectReg(4'd5, 32'hffff_ff85, "testReg r5 ldi negative");
      expectReg(4'd6, 32'h0000_7fff, "testReg r6 ldi positive");
      expectReg(4'd7, 32'h0000_7fff, "testReg r7 add r0");
   endtask

   initial
   begin
      waitPowerReset();
      resetBehavior();
      arithLogic();
      portIo();
      controlFlow();
      retireTiming();
      regZeroAndSignExt();
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

//--- sim.f
src/compPkg.sv
src/instrDecode.sv
src/aluExecute.sv
src/resultWrite.sv
src/comp.sv
sim/tbClock.sv
sim/compTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module compTb -f sim.f -o compSim

out=$(./obj_dir/compSim || true)
echo "$out"

if echo "$out" | grep -q "TEST RESULT: PASS"; then
   exit 0
fi
exit 1
